/* logic/mem_ctrl_pkg.sv */
/*
  Shared types, encodings and timing for the video memory controller.
  The SDRAM is 4 banks x 2048 rows x 256 columns of 32-bit words, 8 MB in all.
*/
`default_nettype none

package mem_ctrl_pkg;

  typedef logic [22:0] byte_addr_t;  // client byte address
  typedef logic [20:0] word_addr_t;  // {bank[20:19], row[18:8], col[7:0]}
  typedef logic [31:0] data32_t;     // one sdram word
  typedef logic [15:0] data16_t;     // half-word picked by byte addr bit 1
  typedef logic [3:0]  lane_mask_t;  // dqm, 1 = lane masked, not written

  // access size as given by the client
  typedef logic [1:0] size_t;
  localparam size_t SIZE_8    = 2'b00;
  localparam size_t SIZE_16   = 2'b01;
  localparam size_t SIZE_32   = 2'b10;
  localparam size_t SIZE_RSVD = 2'b11;  // no meaning, treated as a client error

  // command bits {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    NOP       = 4'b0111,
    ACTIVE    = 4'b0011,
    READ      = 4'b0101,
    WRITE     = 4'b0100,
    PRECHARGE = 4'b0010,
    REFRESH   = 4'b0001,
    LOAD_MODE = 4'b0000
  } sdram_cmd_t;

  // timing in clk cycles
  localparam int CAS_LATENCY = 2;  // READ to data on dq
  localparam int T_RCD       = 2;  // ACTIVE to READ or WRITE
  localparam int T_RFC       = 7;  // REFRESH to next command
  localparam int T_WR_DONE   = 3;  // WRITE to idle, covers write recovery and auto-precharge

endpackage

`default_nettype wire

/* logic/mem_op_if.sv */
/*
  One decoded SDRAM operation, from the request decoder to the sequencer.
  The go pulses only rise while busy is low and are taken in the same cycle.
*/
`default_nettype none

interface mem_op_if;

  import mem_ctrl_pkg::*;

  logic       go_read;     // single-cycle pulses
  logic       go_write;
  logic       go_refresh;
  word_addr_t word_addr;   // word address of the access
  data32_t    wdata;       // lane-replicated write data
  lane_mask_t wmask;       // dqm for the write
  logic       busy;        // sequencer not in idle

  modport decode (
    output go_read, go_write, go_refresh, word_addr, wdata, wmask,
    input  busy
  );

  modport sequencer (
    input  go_read, go_write, go_refresh, word_addr, wdata, wmask,
    output busy
  );

endinterface

`default_nettype wire

/* logic/mem_req_decode.sv */
/*
  Request decoder. Turns client strobes into one operation pulse, builds
  the word address, write mask and replicated write data, and keeps a sticky
  fail flag for strobes given while busy or given together.
*/
`default_nettype none

module mem_req_decode (
  input  wire logic                     clk,
  input  wire logic                     resetn,
  input  wire logic                     read,
  input  wire logic                     write,
  input  wire logic                     refresh,
  input  wire mem_ctrl_pkg::byte_addr_t addr,
  input  wire mem_ctrl_pkg::size_t      word_rd_size,
  input  wire mem_ctrl_pkg::size_t      word_wr_size,
  input  wire logic [7:0]               din8,
  input  wire logic [15:0]              din16,
  input  wire mem_ctrl_pkg::data32_t    din32,
  mem_op_if.decode                      op,
  output logic                          rd_half,
  output logic                          fail
);

  import mem_ctrl_pkg::*;

  logic       any_req;    // some strobe this cycle
  logic       multi_req;  // two or more strobes at once
  logic       bad_size;   // reserved size code on a strobe
  lane_mask_t lane_sel;   // one-hot byte lane of addr[1:0]

  assign any_req   = read | write | refresh;
  assign multi_req = (read & write) | (read & refresh) | (write & refresh);
  assign bad_size  = (read & (word_rd_size == SIZE_RSVD)) |
                     (write & (word_wr_size == SIZE_RSVD));

  // read wins, then write, then refresh; nothing goes out while busy
  assign op.go_read    = read & ~op.busy;
  assign op.go_write   = write & ~read & ~op.busy;
  assign op.go_refresh = refresh & ~read & ~write & ~op.busy;

  assign op.word_addr = addr[22:2];  // drop the byte offset
  assign lane_sel     = 4'b0001 << addr[1:0];

  always_comb begin
    case (word_wr_size)
      SIZE_8: begin
        op.wdata = {4{din8}};                      // byte on every lane
        op.wmask = ~lane_sel;                      // only the addressed lane
      end
      SIZE_16: begin
        op.wdata = {2{din16}};                     // half-word on both halves
        op.wmask = addr[1] ? 4'b0011 : 4'b1100;    // upper or lower half
      end
      SIZE_32: begin
        op.wdata = din32;
        op.wmask = 4'b0000;                        // whole word
      end
      default: begin
        op.wdata = din32;
        op.wmask = 4'b1111;                        // reserved size writes nothing
      end
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      rd_half <= 1'b0;
      fail    <= 1'b0;
    end else begin
      if (op.go_read) begin
        rd_half <= addr[1];                        // held for the aligner until next read
      end
      if ((any_req & op.busy) | multi_req | bad_size) begin
        fail <= 1'b1;                              // sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sdram_sequencer.sv */
/*
  SDRAM command sequencer. Runs the power-up sequence, then single-word
  reads and writes with auto-precharge and auto-refresh, all at fixed
  timing. Commands and pins are registered.
*/
`default_nettype none

module sdram_sequencer #(
  parameter int INIT_CYCLES = 10800
) (
  input  wire logic                    clk,
  input  wire logic                    resetn,
  mem_op_if.sequencer                  op,
  output logic                         capture,
  output mem_ctrl_pkg::data32_t        rdata,
  output logic                         enabled,
  inout  wire [31:0]                   sdram_dq,
  output logic [10:0]                  sdram_addr,
  output logic [1:0]                   sdram_ba,
  output logic                         sdram_cs_n,
  output logic                         sdram_ras_n,
  output logic                         sdram_cas_n,
  output logic                         sdram_we_n,
  output logic                         sdram_cke,
  output mem_ctrl_pkg::lane_mask_t     sdram_dqm
);

  import mem_ctrl_pkg::*;

  localparam int CNT_W = $clog2(INIT_CYCLES + 16);  // wide enough for every wait
  localparam int T_MRD = 2;                          // LOAD_MODE to enabled
  // A10..A0: write burst as programmed, CL from package, sequential, burst 1
  localparam logic [10:0] MODE_WORD = {4'b0000, 3'(CAS_LATENCY), 1'b0, 3'b000};

  typedef enum logic [3:0] {
    INIT_WAIT,
    INIT_PRECHARGE,
    INIT_REFRESH,
    INIT_MODE,
    IDLE,
    ACTIVATE,
    RW,
    WAIT_DONE,
    REFRESH_WAIT
  } state_t;

  state_t           state;
  sdram_cmd_t       cmd;         // command on the pins
  logic [CNT_W-1:0] cnt;         // cycles left in the current wait
  logic             ref_second;  // first init refresh already issued
  logic             lat_read;    // accepted op is a read
  logic             dq_oe;       // dq driven, WRITE cycle only
  logic             accept_rw;
  word_addr_t       lat_addr;
  data32_t          lat_wdata;
  lane_mask_t       lat_mask;
  logic [1:0]       lat_bank;
  logic [7:0]       lat_col;

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
  assign sdram_cke = 1'b1;                         // never in power-down
  assign sdram_dq  = dq_oe ? lat_wdata : 'z;
  assign op.busy   = (state != IDLE);

  assign accept_rw = (state == IDLE) & (op.go_read | op.go_write);
  assign lat_bank  = lat_addr[20:19];
  assign lat_col   = lat_addr[7:0];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state      <= INIT_WAIT;
      cnt        <= CNT_W'(INIT_CYCLES - 1);
      cmd        <= NOP;
      sdram_addr <= '0;
      sdram_ba   <= '0;
      sdram_dqm  <= '0;
      dq_oe      <= 1'b0;
      capture    <= 1'b0;
      enabled    <= 1'b0;
      ref_second <= 1'b0;
      lat_read   <= 1'b0;
    end else begin
      cmd       <= NOP;                            // every command lasts one cycle
      dq_oe     <= 1'b0;
      capture   <= 1'b0;
      sdram_dqm <= '0;
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      case (state)
        INIT_WAIT: if (cnt == '0) begin
          cmd        <= PRECHARGE;
          sdram_addr <= 11'h400;                   // A10 high, all banks
          cnt        <= CNT_W'(T_RCD - 1);         // tRP
          state      <= INIT_PRECHARGE;
        end
        INIT_PRECHARGE: if (cnt == '0) begin
          cmd   <= REFRESH;
          cnt   <= CNT_W'(T_RFC - 1);
          state <= INIT_REFRESH;
        end
        INIT_REFRESH: if (cnt == '0) begin
          cnt <= CNT_W'(T_RFC - 1);
          if (!ref_second) begin
            cmd        <= REFRESH;                 // second of two
            ref_second <= 1'b1;
          end else begin
            cmd        <= LOAD_MODE;
            sdram_ba   <= 2'b00;
            sdram_addr <= MODE_WORD;
            cnt        <= CNT_W'(T_MRD);
            state      <= INIT_MODE;
          end
        end
        INIT_MODE: if (cnt == '0) begin
          enabled <= 1'b1;
          state   <= IDLE;
        end
        IDLE: begin
          if (op.go_read || op.go_write) begin
            cmd        <= ACTIVE;
            sdram_ba   <= op.word_addr[20:19];     // bank
            sdram_addr <= op.word_addr[18:8];      // row
            lat_read   <= op.go_read;
            cnt        <= CNT_W'(T_RCD - 1);
            state      <= ACTIVATE;
          end else if (op.go_refresh) begin
            cmd   <= REFRESH;
            cnt   <= CNT_W'(T_RFC);
            state <= REFRESH_WAIT;
          end
        end
        ACTIVATE: if (cnt == '0) begin
          cmd        <= lat_read ? READ : WRITE;
          sdram_ba   <= lat_bank;
          sdram_addr <= {1'b1, 2'b00, lat_col};    // A10 = auto-precharge
          if (!lat_read) begin
            dq_oe     <= 1'b1;                     // data goes with the WRITE
            sdram_dqm <= lat_mask;
          end
          state <= RW;
        end
        RW: begin
          cnt   <= lat_read ? CNT_W'(CAS_LATENCY) : CNT_W'(T_WR_DONE - 1);
          state <= WAIT_DONE;
        end
        WAIT_DONE: begin
          if (lat_read && cnt == CNT_W'(1)) begin
            capture <= 1'b1;                       // rdata holds the word next cycle
          end
          if (cnt == '0) begin
            state <= IDLE;
          end
        end
        REFRESH_WAIT: if (cnt == '0) begin
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // payload, sampled dq and the fields of the accepted op
  always_ff @(posedge clk) begin
    rdata <= sdram_dq;
    if (accept_rw) begin
      lat_addr  <= op.word_addr;
      lat_wdata <= op.wdata;
      lat_mask  <= op.wmask;
    end
  end

endmodule

`default_nettype wire

/* logic/mem_read_align.sv */
/*
  Read data aligner. Stores the word read from SDRAM and the half-word
  picked by the read's address bit 1, and holds both until the next read.
*/
`default_nettype none

module mem_read_align (
  input  wire logic                  clk,
  input  wire logic                  resetn,
  input  wire logic                  capture,   // rdata valid this cycle
  input  wire mem_ctrl_pkg::data32_t rdata,     // registered dq
  input  wire logic                  rd_half,   // byte addr bit 1 of the read
  output mem_ctrl_pkg::data32_t      dout32,
  output mem_ctrl_pkg::data16_t      dout16
);

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      dout32 <= '0;
      dout16 <= '0;
    end else if (capture) begin
      dout32 <= rdata;                               // whole word
      dout16 <= rd_half ? rdata[31:16] : rdata[15:0]; // upper half at addr bit 1 set
    end
  end

endmodule

`default_nettype wire

/* logic/mem_ctrl_top.sv */
/*
  Memory controller top for the video display processor. A byte-addressed
  read, write and refresh port in front of a 32-bit SDR SDRAM.
*/
`default_nettype none

module mem_ctrl_top #(
  parameter int INIT_CYCLES = 10800                  // 200 us at 54 MHz
) (
  input  wire logic                     clk,
  input  wire logic                     resetn,
  input  wire logic                     read,
  input  wire logic                     write,
  input  wire logic                     refresh,
  input  wire mem_ctrl_pkg::byte_addr_t addr,
  input  wire mem_ctrl_pkg::size_t      word_rd_size,
  input  wire mem_ctrl_pkg::size_t      word_wr_size,
  input  wire logic [7:0]               din8,
  input  wire logic [15:0]              din16,
  input  wire mem_ctrl_pkg::data32_t    din32,
  output mem_ctrl_pkg::data16_t         dout16,
  output mem_ctrl_pkg::data32_t         dout32,
  output logic                          busy,
  output logic                          enabled,
  output logic                          fail,
  inout  wire [31:0]                    sdram_dq,
  output logic [10:0]                   sdram_addr,
  output logic [1:0]                    sdram_ba,
  output logic                          sdram_cs_n,
  output logic                          sdram_ras_n,
  output logic                          sdram_cas_n,
  output logic                          sdram_we_n,
  output logic                          sdram_cke,
  output mem_ctrl_pkg::lane_mask_t      sdram_dqm
);

  import mem_ctrl_pkg::*;

  logic    capture;  // sequencer to aligner
  data32_t rdata;
  logic    rd_half;  // decoder to aligner

  mem_op_if op_if ();

  mem_req_decode i_decode (
    .clk          (clk),
    .resetn       (resetn),
    .read         (read),
    .write        (write),
    .refresh      (refresh),
    .addr         (addr),
    .word_rd_size (word_rd_size),
    .word_wr_size (word_wr_size),
    .din8         (din8),
    .din16        (din16),
    .din32        (din32),
    .op           (op_if),
    .rd_half      (rd_half),
    .fail         (fail)
  );

  sdram_sequencer #(
    .INIT_CYCLES (INIT_CYCLES)
  ) i_seq (
    .clk         (clk),
    .resetn      (resetn),
    .op          (op_if),
    .capture     (capture),
    .rdata       (rdata),
    .enabled     (enabled),
    .sdram_dq    (sdram_dq),
    .sdram_addr  (sdram_addr),
    .sdram_ba    (sdram_ba),
    .sdram_cs_n  (sdram_cs_n),
    .sdram_ras_n (sdram_ras_n),
    .sdram_cas_n (sdram_cas_n),
    .sdram_we_n  (sdram_we_n),
    .sdram_cke   (sdram_cke),
    .sdram_dqm   (sdram_dqm)
  );

  mem_read_align i_align (
    .clk     (clk),
    .resetn  (resetn),
    .capture (capture),
    .rdata   (rdata),
    .rd_half (rd_half),
    .dout32  (dout32),
    .dout16  (dout16)
  );

  assign busy = op_if.busy;  // high through init and every operation

endmodule

`default_nettype wire

/* verif/sdram_model.sv */
/*
  Behavioral SDR SDRAM, 4 banks of 32-bit words. Decodes commands on the
  rising clk edge, writes through the dqm mask and returns read data
  after a CAS latency of two.
*/
`default_nettype none

module sdram_model (
  input  wire logic                     clk,
  inout  wire [31:0]                    dq,
  input  wire logic [10:0]              addr,
  input  wire logic [1:0]               ba,
  input  wire logic                     cs_n,
  input  wire logic                     ras_n,
  input  wire logic                     cas_n,
  input  wire logic                     we_n,
  input  wire logic                     cke,
  input  wire mem_ctrl_pkg::lane_mask_t dqm
);

  import mem_ctrl_pkg::*;

  data32_t     mem [word_addr_t];      // sparse storage, only written words
  logic [10:0] open_row [4];           // row opened by ACTIVE, per bank
  logic [3:0]  cmd;
  word_addr_t  cur;                    // word hit by READ or WRITE
  logic        rd_pend = 1'b0;         // READ seen, data one cycle away
  logic        rd_drive = 1'b0;        // model owns dq
  data32_t     rd_pend_data;
  data32_t     rd_out;
  data32_t     merged;

  assign cmd = {cs_n, ras_n, cas_n, we_n};
  assign cur = {ba, open_row[ba], addr[7:0]};
  assign dq  = rd_drive ? rd_out : 'z;

  // unwritten words read back a pattern built from the full address
  function automatic data32_t word_at(input word_addr_t w);
    return mem.exists(w) ? mem[w] : ({w[10:0], w} ^ 32'h5a5a_0000);
  endfunction

  always @(posedge clk) begin
    rd_drive <= rd_pend;               // data valid at the second edge after READ
    rd_out   <= rd_pend_data;
    rd_pend  <= 1'b0;
    if (cke) begin
      case (cmd)
        ACTIVE: open_row[ba] <= addr;
        READ: begin
          rd_pend      <= 1'b1;
          rd_pend_data <= word_at(cur);
        end
        WRITE: begin
          merged = word_at(cur);
          for (int l = 0; l < 4; l++) begin
            if (!dqm[l]) merged[l*8 +: 8] = dq[l*8 +: 8];  // lane not masked
          end
          mem[cur] = merged;
        end
        default: ;                     // nop, precharge, refresh, mode
      endcase
    end
  end

endmodule

`default_nettype wire

/* verif/mem_ctrl_properties.sv */
/*
  Concurrent checks bound into the memory controller top. They cover command
  legality before start-up, busy length per operation and dq ownership.
*/
`default_nettype none

module mem_ctrl_properties (
  input wire logic clk,
  input wire logic resetn,
  input wire logic read,
  input wire logic write,
  input wire logic refresh,
  input wire logic busy,
  input wire logic enabled,
  input wire logic cs_n,
  input wire logic ras_n,
  input wire logic cas_n,
  input wire logic we_n,
  input wire logic dq_oe
);

  import mem_ctrl_pkg::*;

  logic [3:0] cmd;
  logic       run;             // an accepted op is in flight
  logic [3:0] len;             // busy cycles seen since acceptance
  logic [3:0] exp_len;         // busy cycles the op must take
  logic       err_rw  = 1'b0;  // sticky marks of failed assertions
  logic       err_len = 1'b0;
  logic       err_dq  = 1'b0;
  logic       any_err;         // watched by the testbench

  assign cmd     = {cs_n, ras_n, cas_n, we_n};
  assign any_err = err_rw | err_len | err_dq;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      run     <= 1'b0;
      len     <= '0;
      exp_len <= '0;
    end else if (enabled && !busy && (read || write || refresh)) begin
      run     <= 1'b1;
      len     <= '0;
      exp_len <= (read || write) ? 4'd6 : 4'd8;  // high through cycle 6 or cycle 8
    end else if (run) begin
      if (busy) len <= len + 4'd1;
      else run <= 1'b0;
    end
  end

  a_no_rw_before_enable: assert property (@(posedge clk) disable iff (!resetn)
    !enabled |-> (cmd != READ && cmd != WRITE))
    else begin
      err_rw = 1'b1;
      $error("READ or WRITE command issued before enabled");
    end

  a_busy_length: assert property (@(posedge clk) disable iff (!resetn)
    (run && !busy) |-> (len == exp_len))
    else begin
      err_len = 1'b1;
      $error("busy dropped after %0d cycles, expected %0d", len, exp_len);
    end

  a_dq_write_only: assert property (@(posedge clk) disable iff (!resetn)
    dq_oe |-> (cmd == WRITE))
    else begin
      err_dq = 1'b1;
      $error("dq driven by controller outside a WRITE cycle");
    end

endmodule

bind mem_ctrl_top mem_ctrl_properties i_props (
  .clk     (clk),
  .resetn  (resetn),
  .read    (read),
  .write   (write),
  .refresh (refresh),
  .busy    (busy),
  .enabled (enabled),
  .cs_n    (sdram_cs_n),
  .ras_n   (sdram_ras_n),
  .cas_n   (sdram_cas_n),
  .we_n    (sdram_we_n),
  .dq_oe   (i_seq.dq_oe)
);

`default_nettype wire

/* verif/tb_mem_ctrl.sv */
/*
  Testbench for the memory controller. Drives the request port on the
  falling edge, keeps a shadow copy of memory and checks every read.
*/
`default_nettype none

module tb_mem_ctrl;

  import mem_ctrl_pkg::*;

  logic        clk;
  logic        resetn;
  logic        read;
  logic        write;
  logic        refresh;
  byte_addr_t  addr;
  size_t       word_rd_size;
  size_t       word_wr_size;
  logic [7:0]  din8;
  logic [15:0] din16;
  data32_t     din32;
  data16_t     dout16;
  data32_t     dout32;
  logic        busy;
  logic        enabled;
  logic        fail;
  wire  [31:0] sdram_dq;
  logic [10:0] sdram_addr;
  logic [1:0]  sdram_ba;
  logic        sdram_cs_n;
  logic        sdram_ras_n;
  logic        sdram_cas_n;
  logic        sdram_we_n;
  logic        sdram_cke;
  lane_mask_t  sdram_dqm;

  data32_t    shadow [word_addr_t];  // expected memory contents
  data32_t    last_word;             // dout32 of the last read
  data16_t    last_half;
  byte_addr_t set_addr [4];          // small address set for the mixed run
  byte_addr_t a;
  size_t      sz;
  int         kind;

  mem_ctrl_top #(.INIT_CYCLES(20)) i_dut (.*);

  sdram_model i_sdram (
    .clk   (clk),
    .dq    (sdram_dq),
    .addr  (sdram_addr),
    .ba    (sdram_ba),
    .cs_n  (sdram_cs_n),
    .ras_n (sdram_ras_n),
    .cas_n (sdram_cas_n),
    .we_n  (sdram_we_n),
    .cke   (sdram_cke),
    .dqm   (sdram_dqm)
  );

  always #5 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  // a failed bound assertion ends the run at the next falling edge
  always @(negedge clk) begin
    if (i_dut.i_props.any_err) stop_run("a bound assertion failed");
  end

  task automatic check_value(input string test, input data32_t exp, input data32_t act);
    assert (act == exp) else
      stop_run($sformatf("MISMATCH %s expected %h actual %h", test, exp, act));
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (busy) begin
      @(negedge clk);
      n++;
      if (n > 100) stop_run({"busy never went low during ", what});
    end
  endtask

  task automatic wait_enabled();
    int n;
    n = 0;
    while (!enabled) begin
      @(negedge clk);
      n++;
      if (n > 200) stop_run("enabled never went high after reset");
    end
  endtask

  task automatic apply_reset();
    resetn = 1'b0;
    repeat (2) @(negedge clk);
    resetn = 1'b1;
  endtask

  // byte lane or half-word merge by access size
  task automatic shadow_write(input byte_addr_t wa, input size_t wsz, input data32_t wd);
    data32_t w;
    int      lane;
    w    = shadow.exists(wa[22:2]) ? shadow[wa[22:2]] : 32'h0;
    lane = int'(wa[1:0]);
    case (wsz)
      SIZE_8:  w[lane*8 +: 8] = wd[7:0];
      SIZE_16: w[(lane/2)*16 +: 16] = wd[15:0];
      default: w = wd;
    endcase
    shadow[wa[22:2]] = w;
  endtask

  task automatic do_write(input byte_addr_t wa, input size_t wsz, input data32_t wd);
    wait_idle("write");
    addr         = wa;
    word_wr_size = wsz;
    din8         = wd[7:0];
    din16        = wd[15:0];
    din32        = wd;
    write        = 1'b1;
    @(negedge clk);
    write = 1'b0;
    wait_idle("write");
    shadow_write(wa, wsz, wd);
  endtask

  task automatic do_read(input string test, input byte_addr_t ra, input size_t rsz);
    data32_t exp;
    wait_idle(test);
    addr         = ra;
    word_rd_size = rsz;
    read         = 1'b1;
    @(negedge clk);
    read = 1'b0;
    wait_idle(test);
    exp = shadow[ra[22:2]];
    check_value(test, exp, dout32);
    check_value(test, 32'(ra[1] ? exp[31:16] : exp[15:0]), 32'(dout16));
    last_word = exp;
    last_half = ra[1] ? exp[31:16] : exp[15:0];
  endtask

  task automatic do_refresh();
    wait_idle("refresh");
    refresh = 1'b1;
    @(negedge clk);
    refresh = 1'b0;
    wait_idle("refresh");
  endtask

  initial begin
    clk          = 1'b0;
    resetn       = 1'b0;
    read         = 1'b0;
    write        = 1'b0;
    refresh      = 1'b0;
    addr         = '0;
    word_rd_size = SIZE_32;
    word_wr_size = SIZE_32;
    din8         = '0;
    din16        = '0;
    din32        = '0;
    void'($urandom(32'h0592d09d));
    apply_reset();

    wait_enabled();                                  // init
    check_value("init_busy", 32'h0, 32'(busy));
    check_value("init_fail", 32'h0, 32'(fail));

    repeat (8) begin                                 // full word write and read back
      a = byte_addr_t'($urandom);
      a[1:0] = 2'b00;
      do_write(a, SIZE_32, $urandom);
      do_read("write32_read32", a, SIZE_32);
    end

    a = byte_addr_t'($urandom);                      // one byte per lane then a merged read
    a[1:0] = 2'b00;
    for (int l = 0; l < 4; l++) do_write(a + byte_addr_t'(l), SIZE_8, 32'(8'h11 * (l + 3)));
    do_read("byte_lanes", a, SIZE_32);

    a = byte_addr_t'($urandom);                      // both halves then 16-bit reads
    a[1:0] = 2'b00;
    do_write(a, SIZE_16, 32'(16'hbeef));
    do_write(a + 23'd2, SIZE_16, 32'(16'hcafe));
    do_read("half_low", a, SIZE_16);
    do_read("half_high", a + 23'd2, SIZE_16);

    for (int i = 0; i < 4; i++) begin                // mixed sequence over four words
      set_addr[i] = byte_addr_t'($urandom);
      set_addr[i][1:0] = 2'b00;
      do_write(set_addr[i], SIZE_32, $urandom);
    end
    repeat (40) begin
      kind = int'($urandom % 4);
      sz   = size_t'($urandom % 3);
      a    = set_addr[$urandom % 4] + byte_addr_t'($urandom % 4);
      if (kind == 0) begin
        do_read("mixed_read", a, sz);
      end else begin
        if (kind == 3) do_refresh();
        else do_write(a, sz, $urandom);
        check_value("mixed_hold32", last_word, dout32);
        check_value("mixed_hold16", 32'(last_half), 32'(dout16));
      end
    end

    a = set_addr[0];                                 // write strobe while busy
    do_write(a, SIZE_32, 32'h1234_5678);
    addr         = a;
    word_rd_size = SIZE_32;
    read         = 1'b1;
    @(negedge clk);
    read         = 1'b0;
    write        = 1'b1;
    din32        = 32'hdead_beef;
    word_wr_size = SIZE_32;
    @(negedge clk);
    write = 1'b0;
    wait_idle("fail_flag");
    check_value("fail_flag_data", shadow[a[22:2]], dout32);
    check_value("fail_flag_set", 32'h1, 32'(fail));
    do_read("fail_flag_memory", a, SIZE_32);
    do_refresh();
    check_value("fail_flag_sticky", 32'h1, 32'(fail));
    apply_reset();
    check_value("fail_flag_reset", 32'h0, 32'(fail));
    wait_enabled();
    if (!i_dut.i_props.any_err) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_run("a bound assertion failed");
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
logic/mem_ctrl_pkg.sv
logic/mem_op_if.sv
logic/mem_req_decode.sv
logic/sdram_sequencer.sv
logic/mem_read_align.sv
logic/mem_ctrl_top.sv
verif/sdram_model.sv
verif/mem_ctrl_properties.sv
verif/tb_mem_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_mem_ctrl --Mdir obj_dir -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
